// ==== logic/sqrt_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, cycle counts and vector types for the element-wise
// square-root unit, plus the controller state encoding
//////////////////////////////////////////////////////////////////////

package sqrt_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Unsigned operand
  localparam int DATA_W = 32;
  // Root holds half the operand bits
  localparam int ROOT_W = DATA_W / 2;
  // Vector length and element index
  localparam int COUNT_W = 16;

  //////////////////////////////////////////////////////////////////////
  // Core timing
  //////////////////////////////////////////////////////////////////////

  // Load cycle plus one iteration per root bit
  localparam int SQRT_CYCLES = ROOT_W + 1;
  // Core cycle counter, must reach SQRT_CYCLES-1
  localparam int CYCLE_W = $clog2(SQRT_CYCLES);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [ROOT_W-1:0]  root_t;
  // Remainder never exceeds 2*root, one extra bit
  typedef logic [ROOT_W:0]    rem_t;
  typedef logic [COUNT_W-1:0] count_t;

  // Vector sequencing
  typedef enum logic [1:0] {
    IDLE,
    WAIT_INPUT,
    WAIT_CORE,
    FINISH
  } sqrt_state_e;

endpackage

// ==== logic/sqrt_vector_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Vector sequencer for the square-root unit
// FSM, element counter, operand latch, core start and vector ready
//////////////////////////////////////////////////////////////////////

module sqrt_vector_ctrl (
  input  logic             CLK,
  input  logic             RST,

  // Vector control
  input  logic             start,
  input  logic             round,
  input  sqrt_pkg::count_t size_in,

  // Element input
  input  logic             data_in_enable,
  input  sqrt_pkg::data_t  data_in,

  // Scalar core side
  input  logic             core_done,
  output logic             core_start,
  output sqrt_pkg::data_t  core_operand,

  // Round stage and outside world
  output logic             round_en,
  output logic             ready
);

  import sqrt_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  sqrt_state_e state;

  // Length latched at start
  count_t size_q;
  // Index of the element in flight
  count_t idx;
  count_t idx_next;

  logic last_elem;
  logic accept;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign idx_next  = idx + count_t'(1);
  // Current element closes the vector
  assign last_elem = (idx_next == size_q);

  // Strobes outside WAIT_INPUT are dropped
  assign accept = (state == WAIT_INPUT) && data_in_enable;

  // One cycle in FINISH, lines up with the last data_out_enable
  assign ready = (state == FINISH);

  //////////////////////////////////////////////////////////////////////
  // FSM and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE;
      size_q     <= '0;
      idx        <= '0;
      round_en   <= 1'b0;
      core_start <= 1'b0;
    end else begin
      // Core start is a single-cycle pulse
      core_start <= 1'b0;

      case (state)
        IDLE: begin
          if (start) begin
            size_q   <= size_in;
            round_en <= round;
            idx      <= '0;
            // Empty vector goes straight to ready
            if (size_in == '0) begin
              state <= FINISH;
            end else begin
              state <= WAIT_INPUT;
            end
          end
        end

        WAIT_INPUT: begin
          if (accept) begin
            core_start <= 1'b1;
            state      <= WAIT_CORE;
          end
        end

        WAIT_CORE: begin
          // One element at a time, wait for the core
          if (core_done) begin
            if (last_elem) begin
              state <= FINISH;
            end else begin
              idx   <= idx_next;
              state <= WAIT_INPUT;
            end
          end
        end

        FINISH: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand latch
  //////////////////////////////////////////////////////////////////////

  // Held stable for the core while it loads
  always_ff @(posedge CLK) begin
    if (accept) begin
      core_operand <= data_in;
    end
  end

endmodule

// ==== logic/sqrt_scalar_core.sv ====
//////////////////////////////////////////////////////////////////////
// Iterative integer square root of one operand
// Restoring digit-by-digit method, one root bit per cycle
//////////////////////////////////////////////////////////////////////

module sqrt_scalar_core (
  input  logic            CLK,
  input  logic            RST,

  input  logic            start,
  input  sqrt_pkg::data_t operand,

  output logic            done,
  output sqrt_pkg::root_t root,
  output sqrt_pkg::rem_t  rem
);

  import sqrt_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////

  // Cycle counter and run flag
  logic [CYCLE_W-1:0] cnt;
  logic               busy;
  logic               last_cycle;
  logic               step;

  // Operand shifted out two bits per iteration
  data_t op_sh;

  // Trial subtraction, two bits wider than the remainder
  logic [ROOT_W+2:0] rem_sh;
  logic [ROOT_W+2:0] trial;
  logic [ROOT_W+2:0] diff;
  logic              take;

  //////////////////////////////////////////////////////////////////////
  // Iteration datapath
  //////////////////////////////////////////////////////////////////////

  // Counter reaches SQRT_CYCLES-1 once all root bits are in
  assign last_cycle = busy && (cnt == CYCLE_W'(SQRT_CYCLES - 1));
  assign step       = busy && !last_cycle;

  always_comb begin
    // Bring down the next operand bit pair
    rem_sh = {rem, op_sh[DATA_W-1 -: 2]};
    // 4*root + 1
    trial  = {1'b0, root, 2'b01};
    diff   = rem_sh - trial;
    // Root bit is one when the trial fits
    take   = (rem_sh >= trial);
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        // Load cycle
        busy <= 1'b1;
        cnt  <= '0;
      end else if (last_cycle) begin
        // Result complete, single-cycle done
        busy <= 1'b0;
        done <= 1'b1;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Root and remainder registers
  //////////////////////////////////////////////////////////////////////

  // Hold their value after done until the next start
  always_ff @(posedge CLK) begin
    if (start) begin
      op_sh <= operand;
      root  <= '0;
      rem   <= '0;
    end else if (step) begin
      op_sh <= {op_sh[DATA_W-3:0], 2'b00};
      root  <= {root[ROOT_W-2:0], take};
      // Restore on failed trial, rem stays within 2*root
      if (take) begin
        rem <= diff[ROOT_W:0];
      end else begin
        rem <= rem_sh[ROOT_W:0];
      end
    end
  end

endmodule

// ==== logic/sqrt_round_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Output register with optional round-to-nearest of the root
//////////////////////////////////////////////////////////////////////

module sqrt_round_stage (
  input  logic            CLK,
  input  logic            RST,

  input  logic            done,
  input  logic            round_en,
  input  sqrt_pkg::root_t root,
  input  sqrt_pkg::rem_t  rem,

  output sqrt_pkg::root_t data_out,
  output logic            data_out_enable
);

  import sqrt_pkg::*;

  rem_t  root_ext;
  logic  round_up;
  root_t rounded;

  // rem > root is the same as operand - root^2 > root,
  // i.e. the true root lies at or above root + 0.5
  assign root_ext = {1'b0, root};

  // Saturate at full scale, root + 1 would wrap for the largest operands
  assign round_up = round_en && (rem > root_ext) && (root != '1);

  assign rounded = round_up ? (root + root_t'(1)) : root;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out        <= '0;
      data_out_enable <= 1'b0;
    end else begin
      // One pulse per core result
      data_out_enable <= done;
      // Value held between pulses
      if (done) begin
        data_out <= rounded;
      end
    end
  end

endmodule

// ==== logic/sqrt_vector_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Element-wise vector square root, top level
// Controller, scalar core and rounding output stage
//////////////////////////////////////////////////////////////////////

module sqrt_vector_unit (
  input  logic             CLK,
  input  logic             RST,

  // Vector control
  input  logic             start,
  input  logic             round,
  input  sqrt_pkg::count_t size_in,
  output logic             ready,

  // Element stream in
  input  logic             data_in_enable,
  input  sqrt_pkg::data_t  data_in,

  // Root stream out
  output logic             data_out_enable,
  output sqrt_pkg::root_t  data_out
);

  import sqrt_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////////////////////////

  // Controller to core
  logic  core_start;
  data_t core_operand;

  // Core results
  logic  core_done;
  root_t core_root;
  rem_t  core_rem;

  // Rounding mode for the whole vector
  logic  round_en;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  sqrt_vector_ctrl ctrl_i (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .round          (round),
    .size_in        (size_in),
    .data_in_enable (data_in_enable),
    .data_in        (data_in),
    .core_done      (core_done),
    .core_start     (core_start),
    .core_operand   (core_operand),
    .round_en       (round_en),
    .ready          (ready)
  );

  sqrt_scalar_core core_i (
    .CLK     (CLK),
    .RST     (RST),
    .start   (core_start),
    .operand (core_operand),
    .done    (core_done),
    .root    (core_root),
    .rem     (core_rem)
  );

  // Registers the result one cycle after core_done
  sqrt_round_stage round_i (
    .CLK             (CLK),
    .RST             (RST),
    .done            (core_done),
    .round_en        (round_en),
    .root            (core_root),
    .rem             (core_rem),
    .data_out        (data_out),
    .data_out_enable (data_out_enable)
  );

endmodule

// ==== sim/sqrt_vector_unit_assert.sv ====
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the square-root unit, bound to the top level
// Port-level vector model, expected roots, output timing and ready
//////////////////////////////////////////////////////////////////////

module sqrt_vector_unit_assert (
  input logic             CLK,
  input logic             RST,
  input logic             start,
  input logic             round,
  input sqrt_pkg::count_t size_in,
  input logic             data_in_enable,
  input sqrt_pkg::data_t  data_in,
  input logic             ready,
  input logic             data_out_enable,
  input sqrt_pkg::root_t  data_out
);

  import sqrt_pkg::*;

  // Strobe edge to data_out_enable edge
  localparam int LATENCY = SQRT_CYCLES + 2;

  // Vector model, all from the ports
  logic       vec_active;
  count_t     left;
  logic [7:0] pend;
  data_t      op_q;
  logic       round_q;
  logic       acc;
  logic       exp_ready;
  root_t      exp_root;

  int unsigned timing_fails = 0;
  int unsigned value_fails = 0;
  int unsigned ready_fails = 0;
  int unsigned reset_fails = 0;
  int unsigned fail_count;

  // Bit-by-bit floor root, then nearest, clamped at full scale
  function automatic root_t ref_root(data_t op, logic rnd);
    longint unsigned r;
    longint unsigned c;
    r = 0;
    for (int b = ROOT_W - 1; b >= 0; b--) begin
      c = r | (64'd1 << b);
      if (c * c <= 64'(op)) begin
        r = c;
      end
    end
    if (rnd && (64'(op) - r * r > r) && r < 64'hFFFF) begin
      r = r + 1;
    end
    return root_t'(r);
  endfunction

  // Element taken once the previous root is out (pend at 1 or 0)
  assign acc       = vec_active && (left != '0) && (pend <= 8'd1) && data_in_enable;
  assign exp_ready = vec_active && (left == '0) && (pend <= 8'd1);
  assign exp_root  = ref_root(op_q, round_q);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      vec_active <= 1'b0;
      left       <= '0;
      pend       <= '0;
      op_q       <= '0;
      round_q    <= 1'b0;
    end else begin
      if (pend != 8'd0) begin
        pend <= pend - 8'd1;
      end
      // start only counts between vectors
      if (!vec_active && start) begin
        vec_active <= 1'b1;
        left       <= size_in;
        round_q    <= round;
      end
      if (acc) begin
        op_q <= data_in;
        left <= left - count_t'(1);
        // Output register is seen one edge after it loads
        pend <= 8'(LATENCY + 1);
      end
      if (exp_ready) begin
        vec_active <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////

  // One pulse per accepted element, at the fixed latency
  a_out_timing: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable == (pend == 8'd1))
    else begin
      timing_fails = timing_fails + 1;
      $error("data_out_enable is %b, the vector model expects %b",
        data_out_enable, pend == 8'd1);
    end

  a_out_value: assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> data_out == exp_root)
    else begin
      value_fails = value_fails + 1;
      $error("data_out %h for operand %h round %b, expected %h",
        data_out, op_q, round_q, exp_root);
    end

  // Once per vector, with the last root or right after an empty start
  a_ready: assert property (@(posedge CLK) disable iff (RST) ready == exp_ready)
    else begin
      ready_fails = ready_fails + 1;
      $error("ready is %b, the vector model expects %b", ready, exp_ready);
    end

  a_reset: assert property (@(posedge CLK)
    $fell(RST) |-> !ready && !data_out_enable && data_out == '0)
    else begin
      reset_fails = reset_fails + 1;
      $error("outputs not cleared by reset, data_out %h", data_out);
    end

  assign fail_count = timing_fails + value_fails + ready_fails + reset_fails;

endmodule

bind sqrt_vector_unit sqrt_vector_unit_assert assert_i (
  .CLK             (CLK),
  .RST             (RST),
  .start           (start),
  .round           (round),
  .size_in         (size_in),
  .data_in_enable  (data_in_enable),
  .data_in         (data_in),
  .ready           (ready),
  .data_out_enable (data_out_enable),
  .data_out        (data_out)
);

// ==== sim/sqrt_vector_unit_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the square-root vector unit
// Clock, reset, random vectors with stray strobes, watchdog, summary
//////////////////////////////////////////////////////////////////////

module sqrt_vector_unit_tb;

  import sqrt_pkg::*;

  localparam int SEED         = 76;
  localparam int NUM_VECTORS  = 24;
  localparam int MAX_LEN      = 8;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  // Cycles per element plus one spare element per vector for start and ready
  localparam int ELEM_BUDGET  = 25;
  localparam int WATCHDOG_CYCLES =
    NUM_VECTORS * (MAX_LEN + 1) * ELEM_BUDGET + RESET_CYCLES + 200;

  logic   CLK;
  logic   RST;
  logic   start;
  logic   round;
  count_t size_in;
  logic   data_in_enable;
  data_t  data_in;
  logic   ready;
  logic   data_out_enable;
  root_t  data_out;

  int unsigned checks = 0;
  int unsigned data_errors = 0;
  int unsigned count_errors = 0;
  int unsigned assert_fails;
  int unsigned exp_pulses = 0;
  int unsigned out_pulses;
  int unsigned ready_pulses;

  sqrt_vector_unit dut_i (
    .CLK             (CLK),
    .RST             (RST),
    .start           (start),
    .round           (round),
    .size_in         (size_in),
    .ready           (ready),
    .data_in_enable  (data_in_enable),
    .data_in         (data_in),
    .data_out_enable (data_out_enable),
    .data_out        (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Output pulse counters
  always @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_pulses   <= 0;
      ready_pulses <= 0;
    end else begin
      if (data_out_enable) begin
        out_pulses <= out_pulses + 1;
      end
      if (ready) begin
        ready_pulses <= ready_pulses + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Binary search for the floor root, then round to nearest if asked
  function automatic root_t expected_root(data_t op, logic rnd);
    longint unsigned lo;
    longint unsigned hi;
    longint unsigned mid;
    lo = 0;
    hi = 64'd65536;
    while (hi - lo > 1) begin
      mid = (lo + hi) / 2;
      if (mid * mid <= 64'(op)) begin
        lo = mid;
      end else begin
        hi = mid;
      end
    end
    // Full-scale root cannot go up
    if (rnd && (64'(op) - lo * lo > lo) && lo < 64'd65535) begin
      lo = lo + 1;
    end
    return root_t'(lo);
  endfunction

  // Corners, perfect squares, rounding boundaries and random values
  function automatic data_t pick_operand();
    data_t r;
    r = data_t'(root_t'($urandom));
    case ($urandom % 7)
      0: return '0;
      1: return 32'd1;
      2: return 32'hFFFF_FFFF;
      3: return r * r;
      4: return r * r + r;
      5: return r * r + r + 32'd1;
      default: return data_t'($urandom);
    endcase
  endfunction

  task automatic send_element(input data_t op, input logic rnd, input string name);
    root_t exp;
    exp = expected_root(op, rnd);
    @(posedge CLK);
    data_in_enable <= 1'b1;
    data_in        <= op;
    @(posedge CLK);
    data_in_enable <= 1'b0;
    data_in        <= data_t'($urandom);
    // Stray strobe and start while the root is pending
    if ($urandom % 2 == 0) begin
      repeat (3) @(posedge CLK);
      data_in_enable <= 1'b1;
      start          <= 1'b1;
      round          <= ~rnd;
      size_in        <= count_t'($urandom % 9);
      @(posedge CLK);
      data_in_enable <= 1'b0;
      start          <= 1'b0;
    end
    do begin
      @(posedge CLK);
    end while (!data_out_enable);
    checks++;
    if (data_out !== exp) begin
      data_errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, data_out);
    end
    repeat ($urandom % 4) @(posedge CLK);
  endtask

  task automatic send_vector(input int v);
    int          n;
    logic        rnd;
    int unsigned ready_before;
    n = (v == 1) ? 0 : int'($urandom % (MAX_LEN + 1));
    rnd = v[0];
    ready_before = ready_pulses;
    // Strobe while idle is dropped
    if ($urandom % 3 == 0) begin
      @(posedge CLK);
      data_in_enable <= 1'b1;
      @(posedge CLK);
      data_in_enable <= 1'b0;
    end
    @(posedge CLK);
    start   <= 1'b1;
    size_in <= count_t'(n);
    round   <= rnd;
    @(posedge CLK);
    // Round and size only matter at start
    start   <= 1'b0;
    round   <= 1'($urandom % 2);
    size_in <= count_t'($urandom);
    exp_pulses += n;
    for (int i = 0; i < n; i++) begin
      send_element(pick_operand(), rnd, $sformatf("vec%0d_elem%0d", v, i));
    end
    while (ready_pulses == ready_before) @(posedge CLK);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    RST            = 1'b1;
    start          = 1'b0;
    round          = 1'b0;
    size_in        = '0;
    data_in_enable = 1'b0;
    data_in        = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    checks++;
    // Shown as ready/data_out_enable/data_out
    if (ready !== 1'b0 || data_out_enable !== 1'b0 || data_out !== '0) begin
      count_errors++;
      $display("[ERROR] reset_outputs expected 0/0/%h actual %b/%b/%h",
        root_t'(0), ready, data_out_enable, data_out);
    end
    for (int v = 0; v < NUM_VECTORS; v++) begin
      send_vector(v);
    end
    repeat (5) @(posedge CLK);
    if (out_pulses != exp_pulses) begin
      count_errors++;
      $display("[ERROR] pulse_count expected %0d actual %0d", exp_pulses, out_pulses);
    end
    if (ready_pulses != NUM_VECTORS) begin
      count_errors++;
      $display("[ERROR] ready_count expected %0d actual %0d", NUM_VECTORS, ready_pulses);
    end
    assert_fails = dut_i.assert_i.fail_count;
    $display("Checks %0d, data errors %0d, count errors %0d, assertion failures %0d",
      checks, data_errors, count_errors, assert_fails);
    if (data_errors + count_errors + assert_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== sqrt_vector_unit.f ====
logic/sqrt_pkg.sv
logic/sqrt_vector_ctrl.sv
logic/sqrt_scalar_core.sv
logic/sqrt_round_stage.sv
logic/sqrt_vector_unit.sv
sim/sqrt_vector_unit_assert.sv
sim/sqrt_vector_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the square-root vector unit testbench

VERILATOR   ?= verilator
TOP         ?= sqrt_vector_unit_tb
FILELIST    ?= sqrt_vector_unit.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation ended without a status line"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
